// File: sources.f
+incdir+verilog
verilog/rvPkg.sv
verilog/pipeReg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/hazardUnit.sv
verilog/dataMem.sv
verilog/controlUnit.sv
verilog/datapath.sv
verilog/rvTop.sv
bench/clockGen.sv
bench/rvTb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it into sim.log and fails when the log reports failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --timescale 1ns/1ps --top-module rvTb -f sources.f \
   -Mdir obj_dir -o rvSim \
   && ./obj_dir/rvSim > sim.log 2>&1 \
   || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0

// File: bench/rvTb.sv
// random 200-word program against an ISA model; only stores are observed, so a bad register shows once stored
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvTb;

   localparam int progLen      = 200;
   localparam int endIdx       = progLen - 1;   // slot of the final self-jump
   localparam int bodyRegs     = 8;             // body uses x0..x7, dense dependencies
   localparam int resetTimeout = 10;
   localparam int storeTimeout = 3000;
   localparam int quietCycles  = 50;

   logic             clk;
   logic             reset;
   logic [`XLEN-1:0] pc;
   logic [`XLEN-1:0] instr;
   logic             memWrite;
   logic [`XLEN-1:0] dataAdr;
   logic [`XLEN-1:0] writeData;

   logic [31:0] prog [progLen];
   logic [31:0] rngState;
   logic [31:0] expAdr [$];           // stores in program order
   logic [31:0] expData [$];
   int          errorCount;
   int          checkCount;
   int          seenCount;
   int          pairCount;

   clockGen #(.halfPeriod(20), .resetCycles(3)) clkGen (.clk(clk), .reset(reset));

   rvTop dut (
      .clk(clk), .reset(reset), .pc(pc), .instr(instr),
      .memWrite(memWrite), .dataAdr(dataAdr), .writeData(writeData)
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic int pick(input int n);   // 0 .. n-1
      rngState = xorshift32(rngState);
      return int'(rngState % 32'(n));
   endfunction

   // encoders, straight from the RV32I formats
   function automatic logic [31:0] rTypeWord(input logic subtract, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
      return {1'b0, subtract, 5'd0, rs2, rs1, f3, rd, `OP_RTYPE};
   endfunction

   function automatic logic [31:0] iTypeWord(input logic [31:0] imm, input logic [4:0] rs1,
         input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
      return {imm[11:0], rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] sTypeWord(input logic [31:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], `OP_STORE};   // sw
   endfunction

   function automatic logic [31:0] bTypeWord(input logic [31:0] imm, input logic [4:0] rs2,
         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
   endfunction

   function automatic logic [31:0] jTypeWord(input logic [31:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
   endfunction

   function automatic logic [31:0] fetchWord(input logic [31:0] adr);
      int idx;
      idx = int'((adr - `RESET_PC) >> 2);
      if ($isunknown(adr) || idx >= progLen)
         return jTypeWord(32'd0, 5'd0);        // past the end, spin in place
      return prog[idx];
   endfunction

   function automatic logic [31:0] computeAlu(input logic [2:0] f3, input logic subtract,
         input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000:  return subtract ? a - b : a + b;
         3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic logic [4:0] randomReg();
      return 5'(pick(bodyRegs));
   endfunction

   function automatic logic [2:0] randomAluFunct3();
      case (pick(4))
         0:       return 3'b000;
         1:       return 3'b010;
         2:       return 3'b110;
         default: return 3'b111;
      endcase
   endfunction

   function automatic logic [31:0] randomOffset();
      return 32'(pick(`DMEM_WORDS) * 4);     // word aligned, inside the RAM
   endfunction

   task automatic buildProgram();
      int         idx;
      int         kind;
      int         hop;
      logic [2:0] f3;
      logic [4:0] rd;
      logic [4:0] rs1;
      for (int r = 1; r < 32; r++)
         prog[r - 1] = iTypeWord(32'(pick(4096)), 5'd0, 3'b000, 5'(r), `OP_ITYPE);
      idx = 31;
      while (idx < endIdx) begin
         kind = pick(16);
         f3   = randomAluFunct3();
         rd   = randomReg();
         rs1  = randomReg();
         if (kind < 4) begin
            prog[idx] = rTypeWord(f3 == 3'b000 && pick(2) == 1, randomReg(), rs1, f3, rd);
         end else if (kind < 7) begin
            prog[idx] = iTypeWord(32'(pick(4096)), rs1, f3, rd, `OP_ITYPE);
         end else if (kind < 9) begin
            prog[idx] = sTypeWord(randomOffset(), randomReg(), 5'd0);
         end else if (kind < 11 || (kind < 13 && idx + 1 >= endIdx)) begin
            prog[idx] = iTypeWord(randomOffset(), 5'd0, 3'b010, rd, `OP_LOAD);
         end else if (kind < 13) begin
            rd = 5'(1 + pick(bodyRegs - 1));    // never x0, the use must see it
            prog[idx] = iTypeWord(randomOffset(), 5'd0, 3'b010, rd, `OP_LOAD);
            idx++;
            if (pick(2) == 0)
               prog[idx] = sTypeWord(randomOffset(), rd, 5'd0);   // load-use into store
            else
               prog[idx] = rTypeWord(1'b0, randomReg(), rd, 3'b000, randomReg());
            pairCount++;
         end else begin
            hop = 2 + pick(3);
            if (idx + hop > endIdx)
               hop = endIdx - idx;               // stay inside the program
            if (kind < 15)
               prog[idx] = bTypeWord(32'(hop * 4), (pick(2) == 0) ? rs1 : randomReg(), rs1,
                                     3'(pick(2)));   // same reg twice gives taken beq
            else
               prog[idx] = jTypeWord(32'(hop * 4), rd);
         end
         idx++;
      end
      prog[endIdx] = jTypeWord(32'd0, 5'd0);
   endtask

   // ISA model, one instruction per step, memory zeroed like the RAM after reset
   task automatic runModel();
      logic [31:0] regs [32];
      logic [31:0] mem [`DMEM_WORDS];
      logic [31:0] pcM;
      logic [31:0] nextPc;
      logic [31:0] w;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] adr;
      logic [31:0] immI;
      logic [31:0] immS;
      logic [31:0] immB;
      logic [31:0] immJ;
      int          steps;
      for (int r = 0; r < 32; r++)
         regs[r] = 32'd0;
      for (int m = 0; m < `DMEM_WORDS; m++)
         mem[m] = 32'd0;
      pcM   = `RESET_PC;
      steps = 0;
      while (fetchWord(pcM) != jTypeWord(32'd0, 5'd0) && steps < 5 * progLen) begin
         w      = fetchWord(pcM);
         a      = regs[w[19:15]];
         b      = regs[w[24:20]];
         immI   = {{20{w[31]}}, w[31:20]};
         immS   = {{20{w[31]}}, w[31:25], w[11:7]};
         immB   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
         immJ   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
         nextPc = pcM + 32'd4;
         case (w[6:0])
            `OP_RTYPE: regs[w[11:7]] = computeAlu(w[14:12], w[30], a, b);
            `OP_ITYPE: regs[w[11:7]] = computeAlu(w[14:12], 1'b0, a, immI);
            `OP_LOAD: begin
               adr = a + immI;
               regs[w[11:7]] = mem[int'((adr >> 2) % `DMEM_WORDS)];
            end
            `OP_STORE: begin
               adr = a + immS;
               mem[int'((adr >> 2) % `DMEM_WORDS)] = b;
               expAdr.push_back(adr);
               expData.push_back(b);
            end
            `OP_BRANCH: begin
               if ((w[12] == 1'b0) == (a == b))   // beq on equal, bne on unequal
                  nextPc = pcM + immB;
            end
            `OP_JAL: begin
               regs[w[11:7]] = pcM + 32'd4;     // link
               nextPc = pcM + immJ;
            end
            default: begin
               $display("model met an unknown instruction %h at address %h", w, pcM);
               errorCount++;
            end
         endcase
         regs[0] = 32'd0;
         pcM     = nextPc;
         steps++;
      end
      if (steps >= 5 * progLen) begin
         $display("model never reached the final self-jump");
         errorCount++;
      end
   endtask

   task automatic checkValue(input string what, input logic [31:0] got,
         input logic [31:0] want);
      checkCount++;
      if (got !== want) begin
         errorCount++;
         $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, want);
      end
   endtask

   // one cycle of the store monitor, sampled mid-cycle
   task automatic watchCycle();
      @(negedge clk);
      if (!reset && memWrite !== 1'b0) begin
         if (seenCount < expAdr.size()) begin
            checkValue($sformatf("store %0d address", seenCount), dataAdr, expAdr[seenCount]);
            checkValue($sformatf("store %0d data", seenCount), writeData, expData[seenCount]);
         end else begin
            checkValue("store count", 32'(seenCount + 1), 32'(expAdr.size()));  // extra store
         end
         seenCount++;
      end
   endtask

   // instruction memory: word at pc, driven again on each rising edge and when pc moves
   initial begin
      instr = 32'd0;                     // opcode 0 decodes as a bubble
      @(posedge clk);
      forever begin
         instr <= fetchWord(pc);
         @(pc or posedge clk);
      end
   end

   initial begin
      int cycles;
      errorCount = 0;
      checkCount = 0;
      seenCount  = 0;
      pairCount  = 0;
      rngState   = 32'd51156;
      buildProgram();
      runModel();
      $display("program of %0d words, %0d load-use pairs, %0d stores expected",
               progLen, pairCount, expAdr.size());

      // every falling edge up to the first rising edge with reset low
      cycles = 0;
      do begin
         @(negedge clk);
         cycles++;
         checkValue("pc during reset", pc, `RESET_PC);
         checkValue("memWrite during reset", 32'(memWrite), 32'd0);
      end while (reset && cycles < resetTimeout);

      if (reset) begin
         $display("reset was still high after %0d cycles", resetTimeout);
         errorCount++;
      end else begin
         cycles = 0;
         while (seenCount < expAdr.size() && cycles < storeTimeout) begin
            watchCycle();
            cycles++;
         end
         if (seenCount < expAdr.size()) begin
            $display("timed out after %0d cycles with %0d of %0d stores seen",
                     storeTimeout, seenCount, expAdr.size());
            errorCount++;
         end else begin
            for (int q = 0; q < quietCycles; q++)
               watchCycle();                 // core spins, no store may follow
            checkValue("store total", 32'(seenCount), 32'(expAdr.size()));
         end
      end

      $display("%0d checks, %0d errors, %0d of %0d stores seen",
               checkCount, errorCount, seenCount, expAdr.size());
      if (errorCount == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: bench/clockGen.sv
// free-running clock from time zero; reset is high at start and drops right after the chosen rising edge
`timescale 1ns/1ps

module clockGen #(
   parameter int halfPeriod  = 20,    // ns, 40 ns period
   parameter int resetCycles = 3
) (
   output logic clk,
   output logic reset
);

   initial begin
      clk = 1'b0;
      forever #(halfPeriod) clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (resetCycles) @(posedge clk);
      reset <= 1'b0;                  // released on the edge, like any other input
   end

endmodule

// File: verilog/rvTop.sv
// core plus data memory; instr must return the word at pc in the same cycle
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module rvTop (
   input  logic             clk,
   input  logic             reset,
   output logic [`XLEN-1:0] pc,
   input  logic [`XLEN-1:0] instr,
   output logic             memWrite,    // one cycle per sw
   output logic [`XLEN-1:0] dataAdr,
   output logic [`XLEN-1:0] writeData
);

   logic [`XLEN-1:0]       instrD;
   logic [`XLEN-1:0]       readData;
   rvPkg::immSrc_e         immSrcD;
   rvPkg::ctrlE_t          ctrlE;
   rvPkg::ctrlW_t          ctrlW;
   rvPkg::fwdSel_e         forwardAE;
   rvPkg::fwdSel_e         forwardBE;
   logic                   zeroE;
   logic                   pcSrcE;
   logic                   loadE;
   logic                   regWriteM;
   logic                   stallF;
   logic                   stallD;
   logic                   flushD;
   logic                   flushE;
   logic [`REG_ADDR_W-1:0] rs1D;
   logic [`REG_ADDR_W-1:0] rs2D;
   logic [`REG_ADDR_W-1:0] rs1E;
   logic [`REG_ADDR_W-1:0] rs2E;
   logic [`REG_ADDR_W-1:0] rdE;
   logic [`REG_ADDR_W-1:0] rdM;
   logic [`REG_ADDR_W-1:0] rdW;

   controlUnit cu (
      .clk(clk), .reset(reset),
      .instrD(instrD), .zeroE(zeroE), .flushE(flushE),
      .immSrcD(immSrcD), .ctrlE(ctrlE), .pcSrcE(pcSrcE), .loadE(loadE),
      .memWriteM(memWrite), .regWriteM(regWriteM), .ctrlW(ctrlW)
   );

   datapath dp (
      .clk(clk), .reset(reset),
      .instr(instr), .pc(pc),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
      .forwardAE(forwardAE), .forwardBE(forwardBE),
      .immSrcD(immSrcD), .ctrlE(ctrlE), .pcSrcE(pcSrcE), .ctrlW(ctrlW),
      .instrD(instrD), .zeroE(zeroE),
      .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
      .rdE(rdE), .rdM(rdM), .rdW(rdW),
      .memAdr(dataAdr), .memWData(writeData), .readData(readData)
   );

   hazardUnit hu (
      .rs1D(rs1D), .rs2D(rs2D), .rs1E(rs1E), .rs2E(rs2E),
      .rdE(rdE), .rdM(rdM), .rdW(rdW),
      .loadE(loadE), .pcSrcE(pcSrcE),
      .regWriteM(regWriteM), .regWriteW(ctrlW.regWrite),
      .forwardAE(forwardAE), .forwardBE(forwardBE),
      .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE)
   );

   dataMem dmem (
      .clk(clk), .reset(reset),
      .writeEnable(memWrite), .address(dataAdr),
      .writeData(writeData), .readData(readData)
   );

endmodule

// File: verilog/datapath.sv
// five-stage datapath; word accesses only and no lui, auipc or jalr path
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module datapath (
   input  logic                   clk,
   input  logic                   reset,
   input  logic [`XLEN-1:0]       instr,
   output logic [`XLEN-1:0]       pc,
   input  logic                   stallF,
   input  logic                   stallD,
   input  logic                   flushD,
   input  logic                   flushE,
   input  rvPkg::fwdSel_e         forwardAE,
   input  rvPkg::fwdSel_e         forwardBE,
   input  rvPkg::immSrc_e         immSrcD,
   input  rvPkg::ctrlE_t          ctrlE,
   input  logic                   pcSrcE,
   input  rvPkg::ctrlW_t          ctrlW,
   output logic [`XLEN-1:0]       instrD,
   output logic                   zeroE,
   output logic [`REG_ADDR_W-1:0] rs1D,
   output logic [`REG_ADDR_W-1:0] rs2D,
   output logic [`REG_ADDR_W-1:0] rs1E,
   output logic [`REG_ADDR_W-1:0] rs2E,
   output logic [`REG_ADDR_W-1:0] rdE,
   output logic [`REG_ADDR_W-1:0] rdM,
   output logic [`REG_ADDR_W-1:0] rdW,
   output logic [`XLEN-1:0]       memAdr,
   output logic [`XLEN-1:0]       memWData,
   input  logic [`XLEN-1:0]       readData
);

   logic [`XLEN-1:0]    pcPlus4F;
   logic [`XLEN-1:0]    pcNextF;
   rvPkg::decodeRegs_t  decQ;
   logic [`XLEN-1:0]    rd1D;
   logic [`XLEN-1:0]    rd2D;
   logic [`XLEN-1:0]    immExtD;
   rvPkg::executeRegs_t exeQ;
   logic [`XLEN-1:0]    srcAE;
   logic [`XLEN-1:0]    writeDataE;      // forwarded rs2, also store data
   logic [`XLEN-1:0]    srcBE;
   logic [`XLEN-1:0]    aluResultE;
   logic [`XLEN-1:0]    pcTargetE;
   rvPkg::memRegs_t     memQ;
   rvPkg::wbRegs_t      wbQ;
   logic [`XLEN-1:0]    resultW;

   // fetch
   assign pcPlus4F  = pc + `XLEN'd4;
   assign pcTargetE = exeQ.pc + exeQ.immExt;    // branch and jal target
   assign pcNextF   = pcSrcE ? pcTargetE : pcPlus4F;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pc <= `RESET_PC;
      else if (!stallF)
         pc <= pcNextF;
   end

   // decode
   pipeReg #(.T(rvPkg::decodeRegs_t)) regD (
      .clk(clk), .reset(reset), .enable(!stallD), .clear(flushD),
      .d('{instr: instr, pc: pc, pcPlus4: pcPlus4F}),
      .q(decQ)
   );

   assign instrD = decQ.instr;
   assign rs1D   = decQ.instr[19:15];
   assign rs2D   = decQ.instr[24:20];

   regFile rf (
      .clk(clk),
      .writeEnable(ctrlW.regWrite),
      .readAddr1(rs1D),
      .readAddr2(rs2D),
      .writeAddr(wbQ.rd),
      .writeData(resultW),
      .readData1(rd1D),
      .readData2(rd2D)
   );

   // immediate extension
   always_comb begin
      case (immSrcD)
         rvPkg::IMM_S: immExtD = {{20{decQ.instr[31]}}, decQ.instr[31:25], decQ.instr[11:7]};
         rvPkg::IMM_B: immExtD = {{20{decQ.instr[31]}}, decQ.instr[7], decQ.instr[30:25],
                                  decQ.instr[11:8], 1'b0};
         rvPkg::IMM_J: immExtD = {{12{decQ.instr[31]}}, decQ.instr[19:12], decQ.instr[20],
                                  decQ.instr[30:21], 1'b0};
         default:      immExtD = {{20{decQ.instr[31]}}, decQ.instr[31:20]};   // I-type
      endcase
   end

   // execute
   pipeReg #(.T(rvPkg::executeRegs_t)) regE (
      .clk(clk), .reset(reset), .enable(1'b1), .clear(flushE),
      .d('{rd1: rd1D, rd2: rd2D, pc: decQ.pc, rs1: rs1D, rs2: rs2D,
           rd: decQ.instr[11:7], immExt: immExtD, pcPlus4: decQ.pcPlus4}),
      .q(exeQ)
   );

   assign rs1E = exeQ.rs1;
   assign rs2E = exeQ.rs2;
   assign rdE  = exeQ.rd;

   // operand forwarding
   always_comb begin
      case (forwardAE)
         rvPkg::FWD_WB:  srcAE = resultW;
         rvPkg::FWD_MEM: srcAE = memQ.aluResult;
         default:        srcAE = exeQ.rd1;
      endcase
      case (forwardBE)
         rvPkg::FWD_WB:  writeDataE = resultW;
         rvPkg::FWD_MEM: writeDataE = memQ.aluResult;
         default:        writeDataE = exeQ.rd2;
      endcase
   end

   assign srcBE = ctrlE.aluSrc ? exeQ.immExt : writeDataE;

   alu alu (
      .a(srcAE),
      .b(srcBE),
      .aluOp(ctrlE.aluOp),
      .result(aluResultE),
      .zero(zeroE)
   );

   // memory
   pipeReg #(.T(rvPkg::memRegs_t)) regM (
      .clk(clk), .reset(reset), .enable(1'b1), .clear(1'b0),
      .d('{aluResult: aluResultE, writeData: writeDataE, rd: exeQ.rd,
           pcPlus4: exeQ.pcPlus4}),
      .q(memQ)
   );

   assign rdM      = memQ.rd;
   assign memAdr   = memQ.aluResult;
   assign memWData = memQ.writeData;

   // writeback
   pipeReg #(.T(rvPkg::wbRegs_t)) regW (
      .clk(clk), .reset(reset), .enable(1'b1), .clear(1'b0),
      .d('{aluResult: memQ.aluResult, readData: readData, rd: memQ.rd,
           pcPlus4: memQ.pcPlus4}),
      .q(wbQ)
   );

   assign rdW = wbQ.rd;

   always_comb begin
      case (ctrlW.resultSrc)
         rvPkg::RES_MEM: resultW = wbQ.readData;
         rvPkg::RES_PC4: resultW = wbQ.pcPlus4;    // jal link
         default:        resultW = wbQ.aluResult;
      endcase
   end

endmodule

// File: verilog/controlUnit.sv
// decodes only the kept RV32I subset; any other opcode or funct3 becomes a bubble
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module controlUnit (
   input  logic             clk,
   input  logic             reset,
   input  logic [`XLEN-1:0] instrD,
   input  logic             zeroE,
   input  logic             flushE,
   output rvPkg::immSrc_e   immSrcD,
   output rvPkg::ctrlE_t    ctrlE,
   output logic             pcSrcE,
   output logic             loadE,
   output logic             memWriteM,
   output logic             regWriteM,
   output rvPkg::ctrlW_t    ctrlW
);

   logic [6:0]    op;
   logic [2:0]    funct3;
   logic          funct7b5;
   rvPkg::aluOp_e aluFn;           // R/I-type operation from funct3
   logic          aluKnown;
   rvPkg::ctrlE_t ctrlD;
   rvPkg::ctrlM_t ctrlM;

   assign op       = instrD[6:0];
   assign funct3   = instrD[14:12];
   assign funct7b5 = instrD[30];

   // alu decode, sub only for R-type
   always_comb begin
      aluKnown = 1'b1;
      case (funct3)
         3'b000:  aluFn = (op == `OP_RTYPE && funct7b5) ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
         3'b010:  aluFn = rvPkg::ALU_SLT;
         3'b110:  aluFn = rvPkg::ALU_OR;
         3'b111:  aluFn = rvPkg::ALU_AND;
         default: begin
            aluFn    = rvPkg::ALU_ADD;
            aluKnown = 1'b0;             // shifts, xor, sltu
         end
      endcase
   end

   // main decode
   always_comb begin
      ctrlD   = '0;                      // bubble
      immSrcD = rvPkg::IMM_I;
      case (op)
         `OP_RTYPE, `OP_ITYPE: begin
            ctrlD.regWrite = aluKnown;
            ctrlD.aluOp    = aluFn;
            ctrlD.aluSrc   = (op == `OP_ITYPE);
         end
         `OP_LOAD: if (funct3 == 3'b010) begin
            ctrlD.regWrite  = 1'b1;
            ctrlD.resultSrc = rvPkg::RES_MEM;
            ctrlD.aluSrc    = 1'b1;
         end
         `OP_STORE: if (funct3 == 3'b010) begin
            immSrcD        = rvPkg::IMM_S;
            ctrlD.memWrite = 1'b1;
            ctrlD.aluSrc   = 1'b1;
         end
         `OP_BRANCH: if (funct3[2:1] == 2'b00) begin
            immSrcD        = rvPkg::IMM_B;
            ctrlD.branch   = 1'b1;
            ctrlD.branchNe = funct3[0];
            ctrlD.aluOp    = rvPkg::ALU_SUB;     // compare via zero flag
         end
         `OP_JAL: begin
            immSrcD         = rvPkg::IMM_J;
            ctrlD.regWrite  = 1'b1;
            ctrlD.resultSrc = rvPkg::RES_PC4;   // link
            ctrlD.jump      = 1'b1;
         end
         default: ;
      endcase
   end

   pipeReg #(.T(rvPkg::ctrlE_t)) ctrlRegE (
      .clk(clk), .reset(reset), .enable(1'b1), .clear(flushE),
      .d(ctrlD), .q(ctrlE)
   );

   // taken when beq sees zero or bne sees nonzero
   assign pcSrcE = ctrlE.jump | (ctrlE.branch & (zeroE ^ ctrlE.branchNe));
   assign loadE  = (ctrlE.resultSrc == rvPkg::RES_MEM);

   pipeReg #(.T(rvPkg::ctrlM_t)) ctrlRegM (
      .clk(clk), .reset(reset), .enable(1'b1), .clear(1'b0),
      .d('{regWrite: ctrlE.regWrite, resultSrc: ctrlE.resultSrc,
           memWrite: ctrlE.memWrite}),
      .q(ctrlM)
   );

   assign memWriteM = ctrlM.memWrite;
   assign regWriteM = ctrlM.regWrite;

   pipeReg #(.T(rvPkg::ctrlW_t)) ctrlRegW (
      .clk(clk), .reset(reset), .enable(1'b1), .clear(1'b0),
      .d('{regWrite: ctrlM.regWrite, resultSrc: ctrlM.resultSrc}),
      .q(ctrlW)
   );

endmodule

// File: verilog/dataMem.sv
// word-only RAM; address bits below 2 and above the depth are ignored
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module dataMem (
   input  logic             clk,
   input  logic             reset,
   input  logic             writeEnable,
   input  logic [`XLEN-1:0] address,
   input  logic [`XLEN-1:0] writeData,
   output logic [`XLEN-1:0] readData
);

   localparam int ADR_W = $clog2(`DMEM_WORDS);

   logic [`XLEN-1:0] mem [`DMEM_WORDS];
   logic [ADR_W-1:0] wordAdr;

   assign wordAdr  = address[ADR_W+1:2];
   assign readData = mem[wordAdr];       // combinational read

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         for (int i = 0; i < `DMEM_WORDS; i++)
            mem[i] <= '0;                // defined loads after reset
      end else if (writeEnable) begin
         mem[wordAdr] <= writeData;
      end
   end

endmodule

// File: verilog/hazardUnit.sv
// load-use is the only stall; branches resolve in execute and flush decode and execute
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module hazardUnit (
   input  logic [`REG_ADDR_W-1:0] rs1D,
   input  logic [`REG_ADDR_W-1:0] rs2D,
   input  logic [`REG_ADDR_W-1:0] rs1E,
   input  logic [`REG_ADDR_W-1:0] rs2E,
   input  logic [`REG_ADDR_W-1:0] rdE,
   input  logic [`REG_ADDR_W-1:0] rdM,
   input  logic [`REG_ADDR_W-1:0] rdW,
   input  logic                   loadE,
   input  logic                   pcSrcE,
   input  logic                   regWriteM,
   input  logic                   regWriteW,
   output rvPkg::fwdSel_e         forwardAE,
   output rvPkg::fwdSel_e         forwardBE,
   output logic                   stallF,
   output logic                   stallD,
   output logic                   flushD,
   output logic                   flushE
);

   logic loadUse;

   // memory stage is younger, so it wins
   always_comb begin
      forwardAE = rvPkg::FWD_RF;
      forwardBE = rvPkg::FWD_RF;
      if (rs1E != '0) begin
         if (regWriteM && rs1E == rdM)
            forwardAE = rvPkg::FWD_MEM;
         else if (regWriteW && rs1E == rdW)
            forwardAE = rvPkg::FWD_WB;
      end
      if (rs2E != '0) begin
         if (regWriteM && rs2E == rdM)
            forwardBE = rvPkg::FWD_MEM;
         else if (regWriteW && rs2E == rdW)
            forwardBE = rvPkg::FWD_WB;
      end
   end

   assign loadUse = loadE && (rdE == rs1D || rdE == rs2D);   // data not ready until W
   assign stallF  = loadUse;
   assign stallD  = loadUse;
   assign flushD  = pcSrcE;                // wrong-path fetch
   assign flushE  = pcSrcE | loadUse;      // bubble behind the load

endmodule

// File: verilog/regFile.sv
// 31 registers without reset; software must write a register before reading it
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module regFile (
   input  logic                   clk,
   input  logic                   writeEnable,
   input  logic [`REG_ADDR_W-1:0] readAddr1,
   input  logic [`REG_ADDR_W-1:0] readAddr2,
   input  logic [`REG_ADDR_W-1:0] writeAddr,
   input  logic [`XLEN-1:0]       writeData,
   output logic [`XLEN-1:0]       readData1,
   output logic [`XLEN-1:0]       readData2
);

   logic [`XLEN-1:0] regs [1:31];    // no storage for x0

   // falling-edge write, so decode sees writeback in the same cycle
   always_ff @(negedge clk) begin
      if (writeEnable && writeAddr != '0)
         regs[writeAddr] <= writeData;
   end

   assign readData1 = (readAddr1 != '0) ? regs[readAddr1] : '0;
   assign readData2 = (readAddr2 != '0) ? regs[readAddr2] : '0;

endmodule

// File: verilog/alu.sv
// add, sub, and, or and signed slt only; no carry or flag outputs besides zero
`timescale 1ns/1ps
`include "rvCore_macros.svh"

module alu (
   input  logic [`XLEN-1:0] a,
   input  logic [`XLEN-1:0] b,
   input  rvPkg::aluOp_e    aluOp,
   output logic [`XLEN-1:0] result,
   output logic             zero
);

   logic             subtract;
   logic [`XLEN-1:0] condInvB;
   logic [`XLEN-1:0] sum;
   logic             overflow;

   // one adder, b inverted plus carry-in for sub and slt
   assign subtract = (aluOp == rvPkg::ALU_SUB) || (aluOp == rvPkg::ALU_SLT);
   assign condInvB = subtract ? ~b : b;
   assign sum      = a + condInvB + {{(`XLEN-1){1'b0}}, subtract};
   assign overflow = (a[`XLEN-1] ~^ condInvB[`XLEN-1]) & (a[`XLEN-1] ^ sum[`XLEN-1]);

   always_comb begin
      case (aluOp)
         rvPkg::ALU_AND: result = a & b;
         rvPkg::ALU_OR:  result = a | b;
         rvPkg::ALU_SLT: result = {{(`XLEN-1){1'b0}}, sum[`XLEN-1] ^ overflow};  // true sign
         default:        result = sum;     // add, sub
      endcase
   end

   assign zero = (result == '0);

endmodule

// File: verilog/pipeReg.sv
// generic stage register; clear wins over enable and both zero the payload
`timescale 1ns/1ps

module pipeReg #(
   parameter type T = logic
) (
   input  logic clk,
   input  logic reset,
   input  logic enable,              // low holds the stage
   input  logic clear,               // turns the stage into a bubble
   input  T     d,
   output T     q
);

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         q <= '0;
      else if (clear)
         q <= '0;                    // flush beats stall
      else if (enable)
         q <= d;
   end

endmodule

// File: verilog/rvPkg.sv
// types shared by the pipelined core; all-zero values of the control structs mean a bubble
`include "rvCore_macros.svh"

package rvPkg;

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } aluOp_e;

   typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} immSrc_e;

   typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSrc_e;  // RES_ALU must stay 0

   typedef enum logic [1:0] {FWD_RF, FWD_WB, FWD_MEM} fwdSel_e;

   // control carried into execute
   typedef struct packed {
      logic       regWrite;
      resultSrc_e resultSrc;
      logic       memWrite;
      logic       jump;
      logic       branch;
      logic       branchNe;           // bne when set, beq otherwise
      aluOp_e     aluOp;
      logic       aluSrc;             // immediate as operand b
   } ctrlE_t;

   typedef struct packed {
      logic       regWrite;
      resultSrc_e resultSrc;
      logic       memWrite;
   } ctrlM_t;

   typedef struct packed {
      logic       regWrite;
      resultSrc_e resultSrc;
   } ctrlW_t;

   // payload of the stage registers
   typedef struct packed {
      logic [`XLEN-1:0] instr;
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] pcPlus4;
   } decodeRegs_t;

   typedef struct packed {
      logic [`XLEN-1:0]       rd1;
      logic [`XLEN-1:0]       rd2;
      logic [`XLEN-1:0]       pc;
      logic [`REG_ADDR_W-1:0] rs1;
      logic [`REG_ADDR_W-1:0] rs2;
      logic [`REG_ADDR_W-1:0] rd;
      logic [`XLEN-1:0]       immExt;
      logic [`XLEN-1:0]       pcPlus4;
   } executeRegs_t;

   typedef struct packed {
      logic [`XLEN-1:0]       aluResult;
      logic [`XLEN-1:0]       writeData;
      logic [`REG_ADDR_W-1:0] rd;
      logic [`XLEN-1:0]       pcPlus4;
   } memRegs_t;

   typedef struct packed {
      logic [`XLEN-1:0]       aluResult;
      logic [`XLEN-1:0]       readData;
      logic [`REG_ADDR_W-1:0] rd;
      logic [`XLEN-1:0]       pcPlus4;
   } wbRegs_t;

endpackage

// File: verilog/rvCore_macros.svh
// RV32 word-only core; DMEM_WORDS must be a power of two and RESET_PC word aligned
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// datapath widths
`define XLEN       32              // data and address width
`define REG_ADDR_W 5               // x0..x31

// data memory depth in words, indexed by address word bits
`define DMEM_WORDS 64

// first fetch address after reset
`define RESET_PC   32'h0000_0000

// major opcodes of the kept subset
`define OP_RTYPE   7'b0110011      // add sub and or slt
`define OP_ITYPE   7'b0010011      // addi andi ori slti
`define OP_LOAD    7'b0000011      // lw only
`define OP_STORE   7'b0100011      // sw only
`define OP_BRANCH  7'b1100011      // beq bne
`define OP_JAL     7'b1101111

`endif
